//--- verilog/grayDmaPkg.sv
// Gray DMA package with shared widths, instruction numbers and the RGB565 gray rule
`default_nettype none

package grayDmaPkg;

  typedef logic [31:0] wordT;
  typedef logic [7:0]  memAddrT;
  typedef logic [7:0]  ciIdT;
  typedef logic [8:0]  dmaLenT;
  typedef logic [7:0]  grayT;

  localparam int memDepth = 256;

  // Custom instruction numbers
  localparam ciIdT ciGray      = 8'h0C;
  localparam ciIdT ciMemWrite  = 8'h0D;
  localparam ciIdT ciMemRead   = 8'h0E;
  localparam ciIdT ciDmaStart  = 8'h0F;
  localparam ciIdT ciDmaStatus = 8'h10;

  typedef enum logic [1:0] {dispIdle, dispMemReq, dispMemData, dispResult} dispStateT;
  typedef enum logic [1:0] {dmaIdle, dmaReadReq, dmaReadData, dmaWriteReq} dmaStateT;

  function automatic grayT grayOfPixel(input wordT pixel);
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic [15:0] weighted;
    red      = {pixel[15:11], 3'b000};
    green    = {pixel[10:5], 2'b00};
    blue     = {pixel[4:0], 3'b000};
    // Weights sum to 256, so the sum never exceeds 16 bits
    weighted = red * 16'd54 + green * 16'd183 + blue * 16'd19;
    return weighted[15:8];
  endfunction

endpackage

`default_nettype wire

//--- verilog/memBusIf.sv
// Request path of one master towards the shared pixel memory
`default_nettype none
`timescale 1ns/1ps

interface memBusIf;
  import grayDmaPkg::*;

  logic    req;
  logic    write;
  memAddrT addr;
  wordT    wdata;
  logic    ready;
  logic    rvalid;
  wordT    rdata;

  modport master (output req, write, addr, wdata, input ready, rvalid, rdata);

  modport slave (input req, write, addr, wdata, output ready, rvalid, rdata);

  modport monitor (input req, write, addr, wdata, ready, rvalid, rdata);

endinterface

`default_nettype wire

//--- verilog/dmaCtrlIf.sv
// Job start and status link between the instruction dispatcher and the DMA engine
`default_nettype none
`timescale 1ns/1ps

interface dmaCtrlIf;
  import grayDmaPkg::*;

  logic    start;
  memAddrT src;
  memAddrT dst;
  dmaLenT  len;
  logic    busy;
  dmaLenT  done;

  modport dispatcher (output start, src, dst, len, input busy, done);

  modport engine (input start, src, dst, len, output busy, done);

endinterface

`default_nettype wire

//--- verilog/memArbiter.sv
// Round-robin arbiter sharing the pixel memory between the dispatcher and the DMA engine
`default_nettype none
`timescale 1ns/1ps

module memArbiter (
  input wire      s_systemClock,
  input wire      s_pllLocked,
  memBusIf.slave  disp,
  memBusIf.slave  dma,
  memBusIf.master mem
);

  logic lastGrantDma;
  logic readOwnerDma;
  logic grantDisp;
  logic grantDma;
  logic accepted;

  // On contention the master not served last wins
  assign grantDisp = disp.req & (~dma.req | lastGrantDma);
  assign grantDma  = dma.req & ~grantDisp;

  assign mem.req   = grantDisp | grantDma;
  assign mem.write = grantDma ? dma.write : disp.write;
  assign mem.addr  = grantDma ? dma.addr : disp.addr;
  assign mem.wdata = grantDma ? dma.wdata : disp.wdata;
  assign accepted  = mem.req & mem.ready;

  assign disp.ready = grantDisp & mem.ready;
  assign dma.ready  = grantDma & mem.ready;

  // Read data goes back to whoever issued the read
  assign disp.rvalid = mem.rvalid & ~readOwnerDma;
  assign dma.rvalid  = mem.rvalid & readOwnerDma;
  assign disp.rdata  = mem.rdata;
  assign dma.rdata   = mem.rdata;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lastGrantDma <= 1'b0;
      readOwnerDma <= 1'b0;
    end else if (accepted) begin
      lastGrantDma <= grantDma;
      if (!mem.write) begin
        readOwnerDma <= grantDma;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/pixelMemory.sv
// Single-port pixel memory that is always ready and returns read data one cycle after acceptance
`default_nettype none
`timescale 1ns/1ps

module pixelMemory (
  input wire     s_systemClock,
  input wire     s_pllLocked,
  memBusIf.slave bus
);
  import grayDmaPkg::*;

  wordT memArray [memDepth];
  logic readAccept;
  logic writeAccept;

  assign bus.ready   = 1'b1;
  assign readAccept  = bus.req & bus.ready & ~bus.write;
  assign writeAccept = bus.req & bus.ready & bus.write;

  always_ff @(posedge s_systemClock) begin
    if (writeAccept) begin
      memArray[bus.addr] <= bus.wdata;
    end
    if (readAccept) begin
      bus.rdata <= memArray[bus.addr];
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= readAccept;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ciDispatcher.sv
// Custom instruction dispatcher for gray, memory access and DMA control instructions
`default_nettype none
`timescale 1ns/1ps

module ciDispatcher (
  input  wire                   s_systemClock,
  input  wire                   s_pllLocked,
  input  wire                   ciValid,
  input  wire grayDmaPkg::ciIdT ciN,
  input  wire grayDmaPkg::wordT ciDataA,
  input  wire grayDmaPkg::wordT ciDataB,
  input  wire                   resultReady,
  output logic                  ciReady,
  output logic                  resultValid,
  output grayDmaPkg::wordT      ciResult,
  memBusIf.master               bus,
  dmaCtrlIf.dispatcher          dma
);
  import grayDmaPkg::*;

  dispStateT state;
  logic      accept;
  logic      isMemOp;

  assign ciReady     = (state == dispIdle);
  assign resultValid = (state == dispResult);
  assign accept      = ciValid & ciReady;
  assign isMemOp     = (ciN == ciMemWrite) || (ciN == ciMemRead);
  assign bus.req     = (state == dispMemReq);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state     <= dispIdle;
      dma.start <= 1'b0;
    end else begin
      dma.start <= 1'b0;
      case (state)
        dispIdle: begin
          if (accept) begin
            state <= isMemOp ? dispMemReq : dispResult;
            // A busy engine refuses the job
            if (ciN == ciDmaStart && !dma.busy) begin
              dma.start <= 1'b1;
            end
          end
        end
        dispMemReq: begin
          if (bus.ready) begin
            state <= bus.write ? dispResult : dispMemData;
          end
        end
        dispMemData: begin
          if (bus.rvalid) begin
            state <= dispResult;
          end
        end
        default: begin
          if (resultReady) begin
            state <= dispIdle;
          end
        end
      endcase
    end
  end

  // Operands and result captured at acceptance
  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      bus.write <= (ciN == ciMemWrite);
      bus.addr  <= ciDataA[7:0];
      bus.wdata <= ciDataB;
      dma.src   <= ciDataA[7:0];
      dma.dst   <= ciDataB[7:0];
      dma.len   <= ciDataB[16:8];
      case (ciN)
        ciGray:      ciResult <= {24'd0, grayOfPixel(ciDataA)};
        ciDmaStart:  ciResult <= {31'd0, ~dma.busy};
        ciDmaStatus: ciResult <= {dma.busy, 22'd0, dma.done};
        default:     ciResult <= '0;
      endcase
    end else if (state == dispMemData && bus.rvalid) begin
      ciResult <= bus.rdata;
    end
  end

endmodule

`default_nettype wire

//--- verilog/grayDmaEngine.sv
// Background DMA engine converting a block of RGB565 words to gray values
`default_nettype none
`timescale 1ns/1ps

module grayDmaEngine (
  input wire       s_systemClock,
  input wire       s_pllLocked,
  dmaCtrlIf.engine ctrl,
  memBusIf.master  bus
);
  import grayDmaPkg::*;

  dmaStateT state;
  memAddrT  srcBase;
  memAddrT  dstBase;
  dmaLenT   jobLen;
  dmaLenT   doneCount;
  dmaLenT   nextCount;
  grayT     grayValue;

  assign ctrl.busy = (state != dmaIdle);
  assign ctrl.done = doneCount;
  assign nextCount = doneCount + 9'd1;

  // Word index counts the words written so far and addresses wrap at 256
  assign bus.req   = (state == dmaReadReq) || (state == dmaWriteReq);
  assign bus.write = (state == dmaWriteReq);
  assign bus.addr  = bus.write ? dstBase + doneCount[7:0] : srcBase + doneCount[7:0];
  assign bus.wdata = {24'd0, grayValue};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state     <= dmaIdle;
      doneCount <= '0;
    end else begin
      case (state)
        dmaIdle: begin
          if (ctrl.start) begin
            doneCount <= '0;
            state     <= (ctrl.len == '0) ? dmaIdle : dmaReadReq;
          end
        end
        dmaReadReq: begin
          if (bus.ready) begin
            state <= dmaReadData;
          end
        end
        dmaReadData: begin
          if (bus.rvalid) begin
            state <= dmaWriteReq;
          end
        end
        default: begin
          if (bus.ready) begin
            doneCount <= nextCount;
            state     <= (nextCount == jobLen) ? dmaIdle : dmaReadReq;
          end
        end
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (state == dmaIdle && ctrl.start) begin
      srcBase <= ctrl.src;
      dstBase <= ctrl.dst;
      jobLen  <= ctrl.len;
    end
    if (state == dmaReadData && bus.rvalid) begin
      grayValue <= grayOfPixel(bus.rdata);
    end
  end

endmodule

`default_nettype wire

//--- verilog/grayDmaSystem.sv
// Gray DMA system top level with the custom instruction port and shared pixel memory
`default_nettype none
`timescale 1ns/1ps

module grayDmaSystem (
  input  wire                   s_systemClock,
  input  wire                   s_pllLocked,
  input  wire                   ciValid,
  input  wire grayDmaPkg::ciIdT ciN,
  input  wire grayDmaPkg::wordT ciDataA,
  input  wire grayDmaPkg::wordT ciDataB,
  input  wire                   resultReady,
  output logic                  ciReady,
  output logic                  resultValid,
  output grayDmaPkg::wordT      ciResult
);

  memBusIf  dispBus ();
  memBusIf  dmaBus ();
  memBusIf  memBus ();
  dmaCtrlIf dmaCtrl ();

  ciDispatcher dispatcher (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciValid(ciValid),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .resultReady(resultReady),
    .ciReady(ciReady),
    .resultValid(resultValid),
    .ciResult(ciResult),
    .bus(dispBus.master),
    .dma(dmaCtrl.dispatcher)
  );

  grayDmaEngine engine (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ctrl(dmaCtrl.engine),
    .bus(dmaBus.master)
  );

  memArbiter arbiter (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .disp(dispBus.slave),
    .dma(dmaBus.slave),
    .mem(memBus.master)
  );

  pixelMemory memory (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .bus(memBus.slave)
  );

endmodule

`default_nettype wire

//--- bench/memArbiter_chk.sv
// Protocol assertions on the two master ports of the memory arbiter
`default_nettype none
`timescale 1ns/1ps

module memArbiterChk (
  input wire                      s_systemClock,
  input wire                      s_pllLocked,
  input wire                      dispReq,
  input wire                      dispWrite,
  input wire grayDmaPkg::memAddrT dispAddr,
  input wire grayDmaPkg::wordT    dispWdata,
  input wire                      dispReady,
  input wire                      dispRvalid,
  input wire                      dmaReq,
  input wire                      dmaWrite,
  input wire grayDmaPkg::memAddrT dmaAddr,
  input wire grayDmaPkg::wordT    dmaWdata,
  input wire                      dmaReady,
  input wire                      dmaRvalid
);

  // Only one master served per cycle
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !(dispReq && dispReady && dmaReq && dmaReady))
    else $error("Dispatcher and DMA engine accepted in the same cycle");

  // Waiting requests keep their fields
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    dispReq && !dispReady |=> dispReq && $stable({dispWrite, dispAddr, dispWdata}))
    else $error("Dispatcher request changed while waiting");

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    dmaReq && !dmaReady |=> dmaReq && $stable({dmaWrite, dmaAddr, dmaWdata}))
    else $error("DMA engine request changed while waiting");

  // Read data returns to its owner one cycle later
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    dispReq && dispReady && !dispWrite |=> dispRvalid && !dmaRvalid)
    else $error("Dispatcher read not answered on the next cycle");

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    dmaReq && dmaReady && !dmaWrite |=> dmaRvalid && !dispRvalid)
    else $error("DMA engine read not answered on the next cycle");

endmodule

bind memArbiter memArbiterChk arbiterChk (
  .s_systemClock(s_systemClock),
  .s_pllLocked(s_pllLocked),
  .dispReq(disp.req),
  .dispWrite(disp.write),
  .dispAddr(disp.addr),
  .dispWdata(disp.wdata),
  .dispReady(disp.ready),
  .dispRvalid(disp.rvalid),
  .dmaReq(dma.req),
  .dmaWrite(dma.write),
  .dmaAddr(dma.addr),
  .dmaWdata(dma.wdata),
  .dmaReady(dma.ready),
  .dmaRvalid(dma.rvalid)
);

`default_nettype wire

//--- bench/grayDmaTb.sv
// Testbench for the gray DMA system with random instructions and a memory model
`default_nettype none
`timescale 1ns/1ps

module grayDmaTb;
  import grayDmaPkg::*;

  // Rough instruction count including DMA status polls
  localparam int opCount = 1100;

  logic s_systemClock;
  logic s_pllLocked;
  logic ciValid;
  ciIdT ciN;
  wordT ciDataA;
  wordT ciDataB;
  logic resultReady;
  logic ciReady;
  logic resultValid;
  wordT ciResult;

  wordT model [memDepth];
  int   errors;
  int   checks;

  grayDmaSystem DUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciValid(ciValid),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .resultReady(resultReady),
    .ciReady(ciReady),
    .resultValid(resultValid),
    .ciResult(ciResult)
  );

  initial s_systemClock = 1'b0;
  always #4 s_systemClock = ~s_systemClock;

  // RGB565 weighted sum with channels scaled up to 8 bits
  function automatic grayT refGray(input wordT pixel);
    int r;
    int g;
    int b;
    r = int'(pixel[15:11]) * 8;
    g = int'(pixel[10:5]) * 4;
    b = int'(pixel[4:0]) * 8;
    return grayT'((54 * r + 183 * g + 19 * b) >> 8);
  endfunction

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkGray(input string name, input grayT got, input grayT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Starts and ends on a falling edge with the port idle
  task automatic runOp(input ciIdT n, input wordT a, input wordT b, input bit oneCycle,
                       output wordT res);
    int latency;
    if (!ciReady) begin
      errors++;
      $display("Error: ciReady was low when a new instruction was due at %0t", $time);
    end
    ciValid = 1'b1;
    ciN     = n;
    ciDataA = a;
    ciDataB = b;
    @(negedge s_systemClock);
    ciValid = 1'b0;
    latency = 1;
    while (!resultValid) begin
      @(negedge s_systemClock);
      latency++;
    end
    if (oneCycle && latency != 1) begin
      errors++;
      $display("Error: result of instruction %h came after %0d cycles", n, latency);
    end
    if (ciReady) begin
      errors++;
      $display("Error: ciReady was high while a result was pending at %0t", $time);
    end
    res = ciResult;
    resultReady = ($urandom % 3) != 0;
    while (!resultReady) begin
      @(negedge s_systemClock);
      if (!resultValid) begin
        errors++;
        $display("Error: resultValid dropped before the result was taken at %0t", $time);
      end
      if (ciReady) begin
        errors++;
        $display("Error: ciReady rose before the result was taken at %0t", $time);
      end
      checkWord("ciResult", ciResult, res);
      resultReady = ($urandom % 3) != 0;
    end
    @(negedge s_systemClock);
    resultReady = 1'b0;
  endtask

  task automatic memOp(input memAddrT addr, input bit isWrite);
    wordT data;
    wordT res;
    data = $urandom;
    if (isWrite) begin
      runOp(ciMemWrite, {24'd0, addr}, data, 1'b0, res);
      model[addr] = data;
      checkWord("ciResult memWrite", res, '0);
    end else begin
      runOp(ciMemRead, {24'd0, addr}, $urandom, 1'b0, res);
      checkWord("ciResult memRead", res, model[addr]);
    end
  endtask

  // Source and destination must not overlap each other or the free block
  task automatic runJob(input memAddrT src, input memAddrT dst, input dmaLenT len,
                        input memAddrT freeBase);
    wordT res;
    int   i;
    runOp(ciDmaStart, {24'd0, src}, {15'd0, len, dst}, 1'b1, res);
    checkWord("ciResult dmaStart idle", res, 32'd1);
    for (i = 0; i < len; i++) begin
      model[memAddrT'(dst + i)] = {24'd0, refGray(model[memAddrT'(src + i)])};
    end
    if (len != 0) begin
      runOp(ciDmaStatus, $urandom, $urandom, 1'b1, res);
      checkWord("ciResult[31] dmaStatus", {31'd0, res[31]}, 32'd1);
      runOp(ciDmaStart, {24'd0, freeBase}, {15'd0, 9'd1, freeBase}, 1'b1, res);
      checkWord("ciResult dmaStart busy", res, '0);
      // Dispatcher traffic contending with the job
      for (i = 0; i < 20; i++) begin
        memOp(freeBase + memAddrT'($urandom % 32), ($urandom % 2) == 0);
      end
    end
    do begin
      runOp(ciDmaStatus, $urandom, $urandom, 1'b1, res);
    end while (res[31]);
    checkWord("ciResult dmaStatus done", res, {23'd0, len});
    for (i = 0; i < len; i++) begin
      memOp(memAddrT'(dst + i), 1'b0);
    end
  endtask

  initial begin
    #(opCount * 400);
    $display("Timeout: the run did not finish in the expected time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    wordT res;
    wordT pixel;
    int   i;
    errors = 0;
    checks = 0;
    void'($urandom(32'h6cfe671f));
    s_pllLocked = 1'b0;
    ciValid     = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    resultReady = 1'b0;
    repeat (2) @(posedge s_systemClock);
    @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    @(negedge s_systemClock);
    if (!ciReady || resultValid) begin
      errors++;
      $display("Error: instruction port not idle after reset");
    end
    runOp(8'h42, 32'h1234, 32'h5678, 1'b1, res);
    checkWord("ciResult unknown", res, '0);
    for (i = 0; i < 300; i++) begin
      pixel = $urandom;
      runOp(ciGray, pixel, $urandom, 1'b1, res);
      checkGray("ciResult[7:0]", res[7:0], refGray(pixel));
      checkWord("ciResult upper bits", {res[31:8], 8'h00}, '0);
    end
    // Fill the whole memory so every later read is defined
    for (i = 0; i < memDepth; i++) begin
      memOp(memAddrT'(i), 1'b1);
    end
    for (i = 0; i < 200; i++) begin
      memOp(memAddrT'($urandom), ($urandom % 2) == 0);
    end
    runJob(8'h10, 8'h80, 9'd64, 8'hC0);
    runJob(8'hF0, 8'h30, 9'd40, 8'h60);
    runJob(8'h00, 8'h00, 9'd0, 8'hC0);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/grayDmaPkg.sv
verilog/memBusIf.sv
verilog/dmaCtrlIf.sv
verilog/memArbiter.sv
verilog/pixelMemory.sv
verilog/ciDispatcher.sv
verilog/grayDmaEngine.sv
verilog/grayDmaSystem.sv
bench/memArbiter_chk.sv
bench/grayDmaTb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module grayDmaTb -f sources.f
	./obj_dir/VgrayDmaTb > sim.log 2>&1; cat sim.log
	grep -q ">>> PASS" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module grayDmaTb -f sources.f

clean:
	rm -rf obj_dir sim.log
